//--- design/dataslot_target.sv
//********************************************************************
// dataslot command registers and update interrupt, clk_sys only
// an update arriving with the irq read wins, irq stays set
//********************************************************************
`timescale 1ns/100ps

module dataslot_target (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  mcu_bus_pkg::reg_acc_t       acc_slot,
	input  mcu_bus_pkg::reg_acc_t       acc_upd,
	output logic [31:0]                 rdata_slot,
	output logic [31:0]                 rdata_upd,
	input  mcu_bus_pkg::dataslot_stat_t stat,
	input  mcu_bus_pkg::dataslot_upd_t  upd,
	output mcu_bus_pkg::dataslot_cmd_t  cmd,
	output logic                        irq
);

	logic [15:0] slot_id;
	logic [31:0] bridgeaddr;
	logic [31:0] length;
	logic [31:0] slotoffset;
	logic        cmd_read;
	logic        cmd_write;
	logic [15:0] upd_id;   // last update notice
	logic [31:0] upd_size;
	logic        ctrl_wr;

	assign ctrl_wr = acc_slot.wr && (acc_slot.offset == mcu_map_pkg::off_slot_ctrl);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			slot_id    <= '0;
			bridgeaddr <= '0;
			length     <= '0;
			slotoffset <= '0;
			cmd_read   <= 1'b0;
			cmd_write  <= 1'b0;
			irq        <= 1'b0;
		end else begin
			cmd_read  <= ctrl_wr && acc_slot.wdata[0]; // one cycle after the wr
			cmd_write <= ctrl_wr && acc_slot.wdata[1];
			if (acc_slot.wr) begin
				case (acc_slot.offset)
					mcu_map_pkg::off_slot_id:    slot_id    <= acc_slot.wdata[15:0];
					mcu_map_pkg::off_bridgeaddr: bridgeaddr <= acc_slot.wdata;
					mcu_map_pkg::off_length:     length     <= acc_slot.wdata;
					mcu_map_pkg::off_slotoffset: slotoffset <= acc_slot.wdata;
					default: ;
				endcase
			end
			if (upd.valid)
				irq <= 1'b1; // set beats clear
			else if (acc_upd.rd && (acc_upd.offset == mcu_map_pkg::off_irq))
				irq <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (upd.valid) begin
			upd_id   <= upd.id;
			upd_size <= upd.size;
		end
	end

	always_comb begin
		case (acc_slot.offset)
			mcu_map_pkg::off_slot_id:    rdata_slot = {16'd0, slot_id};
			mcu_map_pkg::off_bridgeaddr: rdata_slot = bridgeaddr;
			mcu_map_pkg::off_length:     rdata_slot = length;
			mcu_map_pkg::off_slotoffset: rdata_slot = slotoffset;
			mcu_map_pkg::off_slot_ctrl:  rdata_slot = {27'd0, stat.ack, stat.done, stat.err};
			default:                     rdata_slot = 32'd0;
		endcase
		case (acc_upd.offset)
			mcu_map_pkg::off_irq:      rdata_upd = {31'd0, irq};
			mcu_map_pkg::off_upd_id:   rdata_upd = {16'd0, upd_id};
			mcu_map_pkg::off_upd_size: rdata_upd = upd_size;
			default:                   rdata_upd = 32'd0;
		endcase
	end

	assign cmd = '{read: cmd_read, write: cmd_write, id: slot_id, slotoffset: slotoffset,
		bridgeaddr: bridgeaddr, length: length};

endmodule

//--- design/hps_io_port.sv
//********************************************************************
// hps io strobe port, cpu toggles clk bit by register writes
// strobe holds while the host keeps wait_io high
//********************************************************************
`timescale 1ns/100ps

module hps_io_port (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  mcu_bus_pkg::reg_acc_t acc,
	output logic [31:0]           rdata,
	input  mcu_bus_pkg::hps_in_t  hps_in,
	output mcu_bus_pkg::hps_out_t hps_out
);

	mcu_bus_pkg::io_word_u wr_word;
	mcu_bus_pkg::io_word_u rd_word;
	logic [15:0] dout;
	logic        io_clk;
	logic        ss0;
	logic        ss1;
	logic        ss2;
	logic        rack;   // io_clk as seen by the host
	logic        io_ack;
	logic        strobe;

	assign wr_word = acc.wdata; // write view of the same word
	assign strobe  = io_clk && !rack;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			dout   <= '0;
			io_clk <= 1'b0;
			ss0    <= 1'b0;
			ss1    <= 1'b0;
			ss2    <= 1'b0;
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			if (acc.wr && (acc.offset == mcu_map_pkg::off_io)) begin
				dout   <= wr_word.wr.dout;
				io_clk <= wr_word.wr.clk;
				ss0    <= wr_word.wr.ss0;
				ss1    <= wr_word.wr.ss1;
				ss2    <= wr_word.wr.ss2;
			end
			// advance unless a strobe is pending and the host stalls
			if (!hps_in.wait_io || !strobe) begin
				rack   <= io_clk;
				io_ack <= rack; // one enable behind rack
			end
		end
	end

	always_comb begin
		rd_word    = '0;
		rd_word.rd.din  = hps_in.din;
		rd_word.rd.wide = hps_in.wide;
		rd_word.rd.ack  = io_ack;
		rdata = (acc.offset == mcu_map_pkg::off_io) ? rd_word : 32'd0;
	end

	assign hps_out = '{uio: ss2 && !ss1, fpga: ss0 && !ss1, strobe: strobe, dout: dout};

endmodule

//--- design/mcu_bus_pkg.sv
//********************************************************************
// bus and port types of the peripheral block
// wstrb only tells write from read, every write updates the full word
//********************************************************************
package mcu_bus_pkg;

	// cpu native memory bus, request side
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb; // nonzero means write
	} cpu_req_t;

	typedef struct packed {
		logic        ready; // one cycle pulse
		logic [31:0] rdata;
	} cpu_rsp_t;

	// one cycle access strobes into a single block
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [7:0]  offset; // byte address low bits
		logic [31:0] wdata;
	} reg_acc_t;

	// target dataslot command to the host
	typedef struct packed {
		logic        read;  // one cycle pulse
		logic        write; // one cycle pulse
		logic [15:0] id;
		logic [31:0] slotoffset;
		logic [31:0] bridgeaddr;
		logic [31:0] length;
	} dataslot_cmd_t;

	typedef struct packed {
		logic       ack;  // command running
		logic       done; // command finished
		logic [2:0] err;  // zero is ok
	} dataslot_stat_t;

	typedef struct packed {
		logic        valid; // clk_sys pulse
		logic [15:0] id;
		logic [31:0] size;
	} dataslot_upd_t;

	// hps io bus
	typedef struct packed {
		logic        uio;
		logic        fpga;
		logic        strobe;
		logic [15:0] dout;
	} hps_out_t;

	typedef struct packed {
		logic        wait_io;
		logic [15:0] din;
		logic        wide; // 1 = 16 bit host
	} hps_in_t;

	// io register as the cpu writes it
	typedef struct packed {
		logic [10:0] rsvd_hi;
		logic        ss2;
		logic        ss1;
		logic        ss0;
		logic        clk;
		logic        rsvd_16;
		logic [15:0] dout;
	} io_wr_view_t;

	// io register as the cpu reads it
	typedef struct packed {
		logic [13:0] rsvd_hi;
		logic        ack;
		logic        wide;
		logic [15:0] din;
	} io_rd_view_t;

	typedef union packed {
		io_wr_view_t wr;
		io_rd_view_t rd;
	} io_word_u;

endpackage

//--- design/mcu_map_pkg.sv
//********************************************************************
// register page of the peripheral block, addresses 0xFFFF_FF00 upward
// page offsets below 0x80 are unmapped, they answer with zero data
//********************************************************************
package mcu_map_pkg;

	// upper 24 address bits of the register page
	localparam logic [23:0] reg_page = 24'hFFFFFF;

	// block select codes
	localparam logic [1:0] blk_dataslot = 2'd0; // 0x80..0x9f
	localparam logic [1:0] blk_irq      = 2'd1; // 0xa0..0xbf
	localparam logic [1:0] blk_timer    = 2'd2; // 0xc0..0xcf
	localparam logic [1:0] blk_io       = 2'd3; // 0xd0 and up

	// lower bounds of the block windows
	localparam logic [7:0] base_dataslot = 8'h80;
	localparam logic [7:0] base_irq      = 8'hA0;
	localparam logic [7:0] base_timer    = 8'hC0;

	// dataslot command parameters
	localparam logic [7:0] off_slot_id    = 8'h80; // 16 bit id
	localparam logic [7:0] off_bridgeaddr = 8'h84;
	localparam logic [7:0] off_length     = 8'h88;
	localparam logic [7:0] off_slotoffset = 8'h8C;
	localparam logic [7:0] off_slot_ctrl  = 8'h90; // wr cmd pulses, rd status

	// tick period sits in the dataslot window but belongs to the timer
	localparam logic [7:0] off_tick_period = 8'h98;

	// update notice and interrupt
	localparam logic [7:0] off_irq      = 8'hB0; // read clears
	localparam logic [7:0] off_upd_id   = 8'hB4;
	localparam logic [7:0] off_upd_size = 8'hB8;

	// ms counter, write bit 0 to clear
	localparam logic [7:0] off_ms_count = 8'hC8;

	// hps strobe port, also start of the io window
	localparam logic [7:0] off_io = 8'hD0;

endpackage

//--- design/mcu_periph_bus.sv
//********************************************************************
// fixed two cycle latency, one request in flight, no back-pressure
// master must hold valid until ready and drop it or move on after
//********************************************************************
`timescale 1ns/100ps

module mcu_periph_bus (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  mcu_bus_pkg::cpu_req_t cpu_req,
	output mcu_bus_pkg::cpu_rsp_t cpu_rsp,
	output mcu_bus_pkg::reg_acc_t acc_dataslot,
	output mcu_bus_pkg::reg_acc_t acc_timer,
	output mcu_bus_pkg::reg_acc_t acc_io,
	output mcu_bus_pkg::reg_acc_t acc_irq,
	input  logic [31:0]           rdata_dataslot,
	input  logic [31:0]           rdata_timer,
	input  logic [31:0]           rdata_io,
	input  logic [31:0]           rdata_irq
);

	logic        busy;        // request in flight
	logic        issue;
	logic [2:0]  dec;         // {hit, blk}
	logic        acc_cyc_q;   // access pulse cycle
	logic        acc_wr_q;
	logic        acc_rd_q;
	logic [1:0]  acc_blk_q;
	logic [7:0]  acc_off_q;
	logic [31:0] acc_wdata_q;
	logic        rsp_pend_q;  // read data captured, ready next
	logic        rsp_ready_q;
	logic [31:0] rsp_rdata_q;
	logic [31:0] rdata_sel;

	// page and block decode, hit is 0 outside the mapped windows
	function automatic logic [2:0] decode(input logic [31:0] addr);
		logic [7:0] off;
		logic       hit;
		logic [1:0] blk;
		off = addr[7:0];
		hit = (addr[31:8] == mcu_map_pkg::reg_page) && (off >= mcu_map_pkg::base_dataslot);
		if (off == mcu_map_pkg::off_tick_period)
			blk = mcu_map_pkg::blk_timer; // odd one out in the dataslot window
		else if (off >= mcu_map_pkg::off_io)
			blk = mcu_map_pkg::blk_io;
		else if (off >= mcu_map_pkg::base_timer)
			blk = mcu_map_pkg::blk_timer;
		else if (off >= mcu_map_pkg::base_irq)
			blk = mcu_map_pkg::blk_irq;
		else
			blk = mcu_map_pkg::blk_dataslot;
		return {hit, blk};
	endfunction

	assign dec   = decode(cpu_req.addr);
	assign issue = cpu_req.valid && !busy;

	// busy until the ready cycle has passed so a held valid is not reissued
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			busy <= 1'b0;
		end else if (issue) begin
			busy <= 1'b1;
		end else if (rsp_ready_q) begin
			busy <= 1'b0;
		end
	end

	// pipeline flags, edge N issue, N+1 capture, N+2 ready
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			acc_cyc_q   <= 1'b0;
			acc_wr_q    <= 1'b0;
			acc_rd_q    <= 1'b0;
			rsp_pend_q  <= 1'b0;
			rsp_ready_q <= 1'b0;
		end else begin
			acc_cyc_q   <= issue;
			acc_wr_q    <= issue && dec[2] && (|cpu_req.wstrb);
			acc_rd_q    <= issue && dec[2] && !(|cpu_req.wstrb);
			rsp_pend_q  <= acc_cyc_q;
			rsp_ready_q <= rsp_pend_q; // single pulse
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			acc_blk_q   <= dec[1:0];
			acc_off_q   <= cpu_req.addr[7:0];
			acc_wdata_q <= cpu_req.wdata;
		end
		if (acc_cyc_q)
			rsp_rdata_q <= acc_rd_q ? rdata_sel : 32'd0; // zero on writes and misses
	end

	always_comb begin
		case (acc_blk_q)
			mcu_map_pkg::blk_dataslot: rdata_sel = rdata_dataslot;
			mcu_map_pkg::blk_timer:    rdata_sel = rdata_timer;
			mcu_map_pkg::blk_irq:      rdata_sel = rdata_irq;
			default:                   rdata_sel = rdata_io;
		endcase
	end

	// only the selected block sees a strobe
	assign acc_dataslot = '{wr: acc_wr_q && (acc_blk_q == mcu_map_pkg::blk_dataslot),
				rd: acc_rd_q && (acc_blk_q == mcu_map_pkg::blk_dataslot),
				offset: acc_off_q, wdata: acc_wdata_q};
	assign acc_timer    = '{wr: acc_wr_q && (acc_blk_q == mcu_map_pkg::blk_timer),
				rd: acc_rd_q && (acc_blk_q == mcu_map_pkg::blk_timer),
				offset: acc_off_q, wdata: acc_wdata_q};
	assign acc_io       = '{wr: acc_wr_q && (acc_blk_q == mcu_map_pkg::blk_io),
				rd: acc_rd_q && (acc_blk_q == mcu_map_pkg::blk_io),
				offset: acc_off_q, wdata: acc_wdata_q};
	assign acc_irq      = '{wr: acc_wr_q && (acc_blk_q == mcu_map_pkg::blk_irq),
				rd: acc_rd_q && (acc_blk_q == mcu_map_pkg::blk_irq),
				offset: acc_off_q, wdata: acc_wdata_q};

	assign cpu_rsp = '{ready: rsp_ready_q, rdata: rsp_rdata_q};

endmodule

//--- design/mcu_periph_top.sv
//********************************************************************
// peripheral block on the cpu native bus, single clock clk_sys
// ds_upd.valid must already be a clk_sys pulse
//********************************************************************
`timescale 1ns/100ps

module mcu_periph_top (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  mcu_bus_pkg::cpu_req_t       cpu_req,
	output mcu_bus_pkg::cpu_rsp_t       cpu_rsp,
	output mcu_bus_pkg::dataslot_cmd_t  ds_cmd,
	input  mcu_bus_pkg::dataslot_stat_t ds_stat,
	input  mcu_bus_pkg::dataslot_upd_t  ds_upd,
	output logic                        irq,
	input  mcu_bus_pkg::hps_in_t        hps_in,
	output mcu_bus_pkg::hps_out_t       hps_out
);

	mcu_bus_pkg::reg_acc_t acc_dataslot;
	mcu_bus_pkg::reg_acc_t acc_timer;
	mcu_bus_pkg::reg_acc_t acc_io;
	mcu_bus_pkg::reg_acc_t acc_irq;
	logic [31:0] rdata_dataslot;
	logic [31:0] rdata_timer;
	logic [31:0] rdata_io;
	logic [31:0] rdata_irq;

	mcu_periph_bus u_bus (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.cpu_req        (cpu_req),
		.cpu_rsp        (cpu_rsp),
		.acc_dataslot   (acc_dataslot),
		.acc_timer      (acc_timer),
		.acc_io         (acc_io),
		.acc_irq        (acc_irq),
		.rdata_dataslot (rdata_dataslot),
		.rdata_timer    (rdata_timer),
		.rdata_io       (rdata_io),
		.rdata_irq      (rdata_irq)
	);

	// irq window lands in the dataslot block too
	dataslot_target u_dataslot (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.acc_slot   (acc_dataslot),
		.acc_upd    (acc_irq),
		.rdata_slot (rdata_dataslot),
		.rdata_upd  (rdata_irq),
		.stat       (ds_stat),
		.upd        (ds_upd),
		.cmd        (ds_cmd),
		.irq        (irq)
	);

	ms_timer u_timer (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.acc     (acc_timer),
		.rdata   (rdata_timer)
	);

	hps_io_port u_io (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.acc     (acc_io),
		.rdata   (rdata_io),
		.hps_in  (hps_in),
		.hps_out (hps_out)
	);

endmodule

//--- design/ms_timer.sv
//********************************************************************
// ms counter steps every tick_period+1 clk_sys cycles
// tick_period is 0 after reset so the count runs at clock rate
//********************************************************************
`timescale 1ns/100ps

module ms_timer (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  mcu_bus_pkg::reg_acc_t acc,
	output logic [31:0]           rdata
);

	logic [31:0] tick_period;
	logic [31:0] tick_cnt;
	logic [31:0] ms_count;
	logic        clr;

	assign clr = acc.wr && (acc.offset == mcu_map_pkg::off_ms_count) && acc.wdata[0];

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_period <= '0;
			tick_cnt    <= '0;
			ms_count    <= '0;
		end else begin
			if (acc.wr && (acc.offset == mcu_map_pkg::off_tick_period))
				tick_period <= acc.wdata;
			if (clr) begin
				tick_cnt <= '0; // both zero next cycle
				ms_count <= '0;
			end else if (tick_cnt >= tick_period) begin
				tick_cnt <= '0; // >= so a shorter period takes effect at once
				ms_count <= ms_count + 32'd1;
			end else begin
				tick_cnt <= tick_cnt + 32'd1;
			end
		end
	end

	always_comb begin
		case (acc.offset)
			mcu_map_pkg::off_tick_period: rdata = tick_period;
			mcu_map_pkg::off_ms_count:    rdata = ms_count;
			default:                      rdata = 32'd0;
		endcase
	end

endmodule

//--- mcu_periph_top.f
design/mcu_map_pkg.sv
design/mcu_bus_pkg.sv
design/mcu_periph_bus.sv
design/dataslot_target.sv
design/ms_timer.sv
design/hps_io_port.sv
design/mcu_periph_top.sv
test/tb_mcu_periph.sv

//--- test/tb_mcu_periph.sv
//********************************************************************
// plays the cpu master and the host side, one bus request at a time
// inputs change on the falling edge, outputs are sampled there too
//********************************************************************
`timescale 1ns/100ps

module tb_mcu_periph;

	localparam int bus_latency = 2;   // edges from valid sample to ready
	localparam int wait_limit  = 50;  // cycles before any wait gives up
	localparam int tick_p      = 9;
	localparam int ms_wait     = 200;

	logic                        clk_sys = 1'b0;
	logic                        reset_n;
	mcu_bus_pkg::cpu_req_t       cpu_req;
	mcu_bus_pkg::cpu_rsp_t       cpu_rsp;
	mcu_bus_pkg::dataslot_cmd_t  ds_cmd;
	mcu_bus_pkg::dataslot_stat_t ds_stat;
	mcu_bus_pkg::dataslot_upd_t  ds_upd;
	logic                        irq;
	mcu_bus_pkg::hps_in_t        hps_in;
	mcu_bus_pkg::hps_out_t       hps_out;
	logic [15:0] lfsr = 16'd39729;
	int          value_errors = 0;
	int          timeouts     = 0;
	logic        timed_out    = 1'b0; // later bus accesses are skipped
	int          read_pulses  = 0;
	int          write_pulses = 0;

	mcu_periph_top dut0 (.*);

	always #20 clk_sys = ~clk_sys; // 40 ns period

	// command pulses, one falling edge per clk_sys cycle
	always @(negedge clk_sys) begin
		if (ds_cmd.read)
			read_pulses++;
		if (ds_cmd.write)
			write_pulses++;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (timed_out)
			return;
		assert (got === exp) else begin
			value_errors++;
			$display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		timed_out = 1'b1;
		$display("Timeout at %0d ns: no %s within %0d cycles", $time, what, wait_limit);
	endtask

	// one request, valid held until ready, latency checked each time
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
		int   lat;
		logic seen;
		rdata = '0;
		if (timed_out)
			return;
		@(negedge clk_sys);
		cpu_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		lat  = 0;
		seen = 1'b0;
		while (!seen && lat < wait_limit) begin
			@(negedge clk_sys);
			lat++;
			seen = cpu_rsp.ready;
		end
		cpu_req.valid = 1'b0; // dropped inside the ready cycle
		if (!seen) begin
			note_timeout("bus ready");
			return;
		end
		rdata = cpu_rsp.rdata;
		check_value("ready latency", lat - 1, bus_latency); // first edge is N
	endtask

	task automatic write_reg(input logic [7:0] off, input logic [31:0] data);
		logic [31:0] unused;
		bus_access({mcu_map_pkg::reg_page, off}, data, 4'hF, unused);
	endtask

	task automatic read_reg(input logic [7:0] off, output logic [31:0] data);
		bus_access({mcu_map_pkg::reg_page, off}, 32'd0, 4'h0, data);
	endtask

	task automatic close_run;
		$display("Checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	initial begin : stimulus
		logic [31:0] vals [4];
		logic [7:0]  par_off [4];
		logic [31:0] rd;
		logic [31:0] word;
		int          n;
		par_off = '{mcu_map_pkg::off_slot_id, mcu_map_pkg::off_bridgeaddr,
			mcu_map_pkg::off_length, mcu_map_pkg::off_slotoffset};
		reset_n = 1'b0;
		cpu_req = '0;
		ds_stat = '0;
		ds_upd  = '0;
		hps_in  = '0;
		repeat (16) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_value("cpu_rsp.ready", cpu_rsp.ready, 0);
		check_value("irq", irq, 0);
		check_value("ds_cmd.read", ds_cmd.read, 0);
		check_value("ds_cmd.write", ds_cmd.write, 0);
		check_value("hps_out.strobe", hps_out.strobe, 0);
		// command parameters, two random passes
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 4; i++) begin
				rand_bits(32, vals[i]);
				write_reg(par_off[i], vals[i]);
			end
			vals[0] = {16'd0, vals[0][15:0]}; // id is 16 bits wide
			for (int i = 0; i < 4; i++) begin
				read_reg(par_off[i], rd);
				check_value("cpu_rsp.rdata", rd, vals[i]);
			end
			check_value("ds_cmd.id", ds_cmd.id, vals[0]);
			check_value("ds_cmd.bridgeaddr", ds_cmd.bridgeaddr, vals[1]);
			check_value("ds_cmd.length", ds_cmd.length, vals[2]);
			check_value("ds_cmd.slotoffset", ds_cmd.slotoffset, vals[3]);
		end
		bus_access(32'h0000_1000, 32'd0, 4'h0, rd); // outside the page
		check_value("cpu_rsp.rdata", rd, 0);
		read_reg(8'h10, rd); // page hit, below all windows
		check_value("cpu_rsp.rdata", rd, 0);
		// slot ctrl pulses and status
		read_pulses  = 0;
		write_pulses = 0;
		write_reg(mcu_map_pkg::off_slot_ctrl, 32'd1);
		repeat (2) @(negedge clk_sys);
		check_value("ds_cmd.read pulse count", read_pulses, 1);
		check_value("ds_cmd.write pulse count", write_pulses, 0);
		write_reg(mcu_map_pkg::off_slot_ctrl, 32'd2);
		repeat (2) @(negedge clk_sys);
		check_value("ds_cmd.read pulse count", read_pulses, 1);
		check_value("ds_cmd.write pulse count", write_pulses, 1);
		rand_bits(5, word);
		ds_stat = '{ack: word[4], done: word[3], err: word[2:0]};
		read_reg(mcu_map_pkg::off_slot_ctrl, rd);
		check_value("cpu_rsp.rdata", rd, {27'd0, word[4:0]}); // ack, done, err
		// update notice and irq
		rand_bits(16, vals[0]);
		rand_bits(32, vals[1]);
		ds_upd = '{valid: 1'b1, id: vals[0][15:0], size: vals[1]};
		@(negedge clk_sys);
		ds_upd.valid = 1'b0;
		n = 0;
		while (!irq && n < wait_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (!irq)
			note_timeout("irq after update");
		read_reg(mcu_map_pkg::off_upd_id, rd);
		check_value("cpu_rsp.rdata", rd, vals[0]);
		read_reg(mcu_map_pkg::off_upd_size, rd);
		check_value("cpu_rsp.rdata", rd, vals[1]);
		read_reg(mcu_map_pkg::off_irq, rd);
		check_value("cpu_rsp.rdata", rd, 1);
		check_value("irq", irq, 0); // cleared by that read
		read_reg(mcu_map_pkg::off_irq, rd);
		check_value("cpu_rsp.rdata", rd, 0);
		// ms timer, expect ms_wait/(tick_p+1) give or take bus latency
		write_reg(mcu_map_pkg::off_tick_period, tick_p);
		write_reg(mcu_map_pkg::off_ms_count, 32'd1);
		repeat (ms_wait) @(negedge clk_sys);
		read_reg(mcu_map_pkg::off_ms_count, rd);
		n = ms_wait / (tick_p + 1);
		if (!timed_out) begin
			assert ((int'(rd) >= n - 1) && (int'(rd) <= n + 1)) else begin
				value_errors++;
				$display("Error at %0d ns: ms count is %0d, expected %0d +- 1", $time, rd, n);
			end
		end
		read_reg(mcu_map_pkg::off_tick_period, rd);
		check_value("cpu_rsp.rdata", rd, tick_p);
		// hps io, host stalls with wait_io first
		rand_bits(16, vals[0]); // dout
		rand_bits(17, vals[1]); // din and wide
		hps_in = '{wait_io: 1'b1, din: vals[1][15:0], wide: vals[1][16]};
		word = {16'd0, vals[0][15:0]};
		word[17] = 1'b1; // clk
		word[18] = 1'b1; // ss0
		write_reg(mcu_map_pkg::off_io, word);
		check_value("hps_out.fpga", hps_out.fpga, 1);
		check_value("hps_out.dout", hps_out.dout, vals[0]);
		repeat (4) @(negedge clk_sys);
		check_value("hps_out.strobe", hps_out.strobe, 1);
		hps_in.wait_io = 1'b0;
		n = 0;
		while (hps_out.strobe && n < wait_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (hps_out.strobe)
			note_timeout("strobe fall after wait_io low");
		read_reg(mcu_map_pkg::off_io, rd);
		check_value("cpu_rsp.rdata", rd, {14'd0, 1'b1, vals[1][16], vals[1][15:0]});
		word = 32'd0;
		word[20] = 1'b1; // ss2 alone
		write_reg(mcu_map_pkg::off_io, word);
		check_value("hps_out.uio", hps_out.uio, 1);
		check_value("hps_out.fpga", hps_out.fpga, 0);
		word[19] = 1'b1; // ss1 masks uio
		write_reg(mcu_map_pkg::off_io, word);
		check_value("hps_out.uio", hps_out.uio, 0);
		close_run();
	end

endmodule
